//--- soc_bus_pkg.sv
package soc_bus_pkg;

  localparam int bus_addr_w = 32;
  localparam int bus_data_w = 32;
  localparam int bus_strb_w = bus_data_w / 8;

  typedef logic [bus_addr_w-1:0] bus_addr_t;
  typedef logic [bus_data_w-1:0] bus_data_t;
  typedef logic [bus_strb_w-1:0] bus_strb_t;  // all zero on reads

  // master to target, held until ready
  typedef struct packed {
    logic      valid;
    bus_addr_t addr;
    bus_data_t wdata;
    bus_strb_t wstrb;
  } bus_req_t;

  // target to master, ready is a single-cycle pulse
  typedef struct packed {
    logic      ready;
    bus_data_t rdata;
  } bus_rsp_t;

endpackage

//--- soc_map_pkg.sv
package soc_map_pkg;

  // peripheral windows, top is exclusive
  localparam logic [31:0] uart_base_addr  = 32'h1000_0000;
  localparam logic [31:0] uart_top_addr   = 32'h1000_0010;
  localparam logic [31:0] timer_base_addr = 32'h2000_0000;
  localparam logic [31:0] timer_top_addr  = 32'h2000_0010;

  // uart registers
  localparam logic [31:0] uart_tx_offset = 32'h0000_0000;  // write byte, read busy
  localparam logic [31:0] uart_rx_offset = 32'h0000_0004;  // {valid, byte}

  // timer registers
  localparam logic [31:0] timer_time_offset = 32'h0000_0000;
  localparam logic [31:0] timer_cmp_offset  = 32'h0000_0004;

endpackage

//--- bus_decoder.sv
`timescale 1ns/1ps

module bus_decoder (
  input  logic                  clk,
  input  logic                  rst,
  input  soc_bus_pkg::bus_req_t bus_req,
  output soc_bus_pkg::bus_rsp_t bus_rsp,
  output soc_bus_pkg::bus_req_t bram_req,
  output soc_bus_pkg::bus_req_t uart_req,
  output soc_bus_pkg::bus_req_t timer_req,
  input  soc_bus_pkg::bus_rsp_t bram_rsp,
  input  soc_bus_pkg::bus_rsp_t uart_rsp,
  input  soc_bus_pkg::bus_rsp_t timer_rsp
);
  import soc_map_pkg::*;

  logic in_uart;
  logic in_timer;

  assign in_uart  = (bus_req.addr >= uart_base_addr) && (bus_req.addr < uart_top_addr);
  assign in_timer = (bus_req.addr >= timer_base_addr) && (bus_req.addr < timer_top_addr);

  always_comb begin
    bram_req        = bus_req;
    bram_req.valid  = bus_req.valid && !in_uart && !in_timer;  // default target

    uart_req        = bus_req;
    uart_req.addr   = bus_req.addr ^ uart_base_addr;
    uart_req.valid  = bus_req.valid && in_uart;

    timer_req       = bus_req;
    timer_req.addr  = bus_req.addr ^ timer_base_addr;
    timer_req.valid = bus_req.valid && in_timer;
  end

  always_comb begin
    if (bram_rsp.ready) begin
      bus_rsp = bram_rsp;
    end else if (uart_rsp.ready) begin
      bus_rsp = uart_rsp;
    end else if (timer_rsp.ready) begin
      bus_rsp = timer_rsp;
    end else begin
      bus_rsp.ready = 1'b0;
      bus_rsp.rdata = '0;
    end
  end

  a_one_target: assert property (@(posedge clk) disable iff (rst)
    $onehot0({bram_req.valid, uart_req.valid, timer_req.valid}));

  // at most one target answers per cycle
  a_one_ready: assert property (@(posedge clk) disable iff (rst)
    $onehot0({bram_rsp.ready, uart_rsp.ready, timer_rsp.ready}));

endmodule

//--- bram_mem.sv
`timescale 1ns/1ps

module bram_mem #(
  parameter int BRAM_DEPTH = 256
) (
  input  logic                  clk,
  input  logic                  rst,
  input  soc_bus_pkg::bus_req_t req,
  output soc_bus_pkg::bus_rsp_t rsp
);
  import soc_bus_pkg::*;

  localparam int idx_w = (BRAM_DEPTH > 1) ? $clog2(BRAM_DEPTH) : 1;

  bus_data_t        mem [BRAM_DEPTH];
  bus_data_t        rdata_q;
  logic             ready_q;
  logic             access;
  logic [idx_w-1:0] idx;

  assign access = req.valid && !ready_q;
  assign idx    = idx_w'(req.addr[31:2] % 30'(BRAM_DEPTH));  // word index, wraps

  always_ff @(posedge clk) begin
    if (rst) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= access;
    end
  end

  always_ff @(posedge clk) begin
    if (access) begin
      for (int b = 0; b < bus_strb_w; b++) begin
        if (req.wstrb[b]) begin
          mem[idx][8*b +: 8] <= req.wdata[8*b +: 8];
        end
      end
      rdata_q <= mem[idx];  // old word on writes
    end
  end

  assign rsp.ready = ready_q;
  assign rsp.rdata = rdata_q;

  a_ready_gap: assert property (@(posedge clk) disable iff (rst) ready_q |=> !ready_q);

endmodule

//--- uart_periph.sv
`timescale 1ns/1ps

module uart_periph #(
  parameter int CLKS_PER_BIT = 8
) (
  input  logic                  clk,
  input  logic                  rst,
  input  soc_bus_pkg::bus_req_t req,
  output soc_bus_pkg::bus_rsp_t rsp,
  input  logic                  rx,
  output logic                  tx
);
  import soc_bus_pkg::*;
  import soc_map_pkg::*;

  localparam int               cnt_w    = $clog2(CLKS_PER_BIT) + 1;
  localparam logic [cnt_w-1:0] bit_last = cnt_w'(CLKS_PER_BIT - 1);
  localparam logic [cnt_w-1:0] bit_half = cnt_w'(CLKS_PER_BIT / 2 - 1);

  localparam logic [1:0] rx_idle  = 2'd0;
  localparam logic [1:0] rx_start = 2'd1;
  localparam logic [1:0] rx_data_st = 2'd2;
  localparam logic [1:0] rx_stop  = 2'd3;

  bus_data_t        rdata_q;
  logic             ready_q;
  logic             access;
  logic             is_write;
  logic             sel_tx;
  logic             sel_rx;

  logic             tx_busy;
  logic             tx_line;
  logic [cnt_w-1:0] tx_cnt;
  logic [3:0]       tx_left;
  logic [8:0]       tx_shift;  // data bits then stop bit

  logic             rx_meta;
  logic             rx_sync;
  logic [1:0]       rx_state;
  logic [cnt_w-1:0] rx_cnt;
  logic [2:0]       rx_idx;
  logic [7:0]       rx_shift;
  logic [7:0]       rx_byte;
  logic             rx_valid;
  logic             rx_done;

  assign access   = req.valid && !ready_q;
  assign is_write = |req.wstrb;
  assign sel_tx   = req.addr[3:2] == uart_tx_offset[3:2];
  assign sel_rx   = req.addr[3:2] == uart_rx_offset[3:2];

  always_ff @(posedge clk) begin
    if (rst) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= access;
    end
  end

  always_ff @(posedge clk) begin
    if (access) begin
      rdata_q <= sel_rx ? {23'd0, rx_valid, rx_byte} : {31'd0, tx_busy};
    end
  end

  // transmitter, writes while busy are dropped
  always_ff @(posedge clk) begin
    if (rst) begin
      tx_busy <= 1'b0;
      tx_line <= 1'b1;
      tx_cnt  <= '0;
      tx_left <= '0;
    end else if (!tx_busy) begin
      if (access && is_write && sel_tx) begin
        tx_busy  <= 1'b1;
        tx_line  <= 1'b0;  // start bit
        tx_cnt   <= '0;
        tx_left  <= 4'd9;
        tx_shift <= {1'b1, req.wdata[7:0]};
      end
    end else if (tx_cnt == bit_last) begin
      tx_cnt <= '0;
      if (tx_left == 4'd0) begin
        tx_busy <= 1'b0;
        tx_line <= 1'b1;
      end else begin
        tx_line  <= tx_shift[0];
        tx_shift <= {1'b1, tx_shift[8:1]};
        tx_left  <= tx_left - 4'd1;
      end
    end else begin
      tx_cnt <= tx_cnt + 1'b1;
    end
  end

  // receiver, sampled mid-bit
  always_ff @(posedge clk) begin
    if (rst) begin
      rx_meta  <= 1'b1;
      rx_sync  <= 1'b1;
      rx_state <= rx_idle;
      rx_cnt   <= '0;
      rx_idx   <= '0;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      case (rx_state)
        rx_idle: begin
          rx_cnt <= '0;
          if (!rx_sync) rx_state <= rx_start;
        end
        rx_start: begin
          if (rx_cnt == bit_half) begin
            rx_cnt   <= '0;
            rx_idx   <= '0;
            rx_state <= rx_sync ? rx_idle : rx_data_st;  // glitch check
          end else begin
            rx_cnt <= rx_cnt + 1'b1;
          end
        end
        rx_data_st: begin
          if (rx_cnt == bit_last) begin
            rx_cnt   <= '0;
            rx_shift <= {rx_sync, rx_shift[7:1]};
            rx_idx   <= rx_idx + 3'd1;
            if (rx_idx == 3'd7) rx_state <= rx_stop;
          end else begin
            rx_cnt <= rx_cnt + 1'b1;
          end
        end
        default: begin
          if (rx_cnt == bit_last) begin
            rx_state <= rx_idle;
            if (rx_sync) rx_byte <= rx_shift;
          end else begin
            rx_cnt <= rx_cnt + 1'b1;
          end
        end
      endcase
    end
  end

  assign rx_done = (rx_state == rx_stop) && (rx_cnt == bit_last) && rx_sync;

  always_ff @(posedge clk) begin
    if (rst) begin
      rx_valid <= 1'b0;
    end else if (rx_done) begin
      rx_valid <= 1'b1;  // new byte wins over a read
    end else if (access && !is_write && sel_rx) begin
      rx_valid <= 1'b0;
    end
  end

  assign tx        = tx_line;
  assign rsp.ready = ready_q;
  assign rsp.rdata = rdata_q;

  a_tx_idle_high: assert property (@(posedge clk) disable iff (rst) !tx_busy |-> tx);

endmodule

//--- timer_regs.sv
`timescale 1ns/1ps

module timer_regs (
  input  logic                   clk,
  input  logic                   rst,
  input  soc_bus_pkg::bus_req_t  req,
  output soc_bus_pkg::bus_rsp_t  rsp,
  input  soc_bus_pkg::bus_data_t time_count,
  output logic                   load,
  output soc_bus_pkg::bus_data_t load_value,
  output soc_bus_pkg::bus_data_t cmp
);
  import soc_bus_pkg::*;
  import soc_map_pkg::*;

  bus_data_t rdata_q;
  logic      ready_q;
  logic      access;
  logic      is_write;
  logic      sel_time;
  logic      sel_cmp;

  assign access   = req.valid && !ready_q;
  assign is_write = |req.wstrb;
  assign sel_time = req.addr[3:2] == timer_time_offset[3:2];
  assign sel_cmp  = req.addr[3:2] == timer_cmp_offset[3:2];

  always_ff @(posedge clk) begin
    if (rst) begin
      ready_q <= 1'b0;
      load    <= 1'b0;
      cmp     <= '1;  // irq stays low
    end else begin
      ready_q <= access;
      load    <= access && is_write && sel_time;  // one-cycle strobe
      if (access && is_write && sel_cmp) cmp <= req.wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (access && is_write && sel_time) begin
      load_value <= req.wdata;
    end
    if (access) begin
      rdata_q <= sel_cmp ? cmp : time_count;
    end
  end

  assign rsp.ready = ready_q;
  assign rsp.rdata = rdata_q;

endmodule

//--- timer_count.sv
`timescale 1ns/1ps

module timer_count #(
  parameter int RTC_DIV = 4
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   load,
  input  soc_bus_pkg::bus_data_t load_value,
  input  soc_bus_pkg::bus_data_t cmp,
  output soc_bus_pkg::bus_data_t time_count,
  output logic                   irq
);
  localparam int div_w = $clog2(RTC_DIV) + 1;

  logic [div_w-1:0] div_cnt;
  logic             tick;

  assign tick = div_cnt == div_w'(RTC_DIV - 1);

  always_ff @(posedge clk) begin
    if (rst) begin
      div_cnt    <= '0;
      time_count <= '0;
      irq        <= 1'b0;
    end else begin
      if (load) begin
        div_cnt    <= '0;  // restart the tick period
        time_count <= load_value;
      end else if (tick) begin
        div_cnt    <= '0;
        time_count <= time_count + 32'd1;
      end else begin
        div_cnt <= div_cnt + 1'b1;
      end
      irq <= time_count >= cmp;  // level, not a pulse
    end
  end

  // only a load may make the count jump
  a_count_step: assert property (@(posedge clk) disable iff (rst)
    !load |=> (time_count - $past(time_count)) <= 32'd1);

endmodule

//--- soc_periph.sv
`timescale 1ns/1ps

module soc_periph #(
  parameter int BRAM_DEPTH   = 256,
  parameter int CLKS_PER_BIT = 8,
  parameter int RTC_DIV      = 4
) (
  input  logic                  clk,
  input  logic                  rst,
  input  soc_bus_pkg::bus_req_t bus_req,
  output soc_bus_pkg::bus_rsp_t bus_rsp,
  input  logic                  rx,
  output logic                  tx,
  output logic                  irq
);
  import soc_bus_pkg::*;

  bus_req_t  bram_req;
  bus_req_t  uart_req;
  bus_req_t  timer_req;
  bus_rsp_t  bram_rsp;
  bus_rsp_t  uart_rsp;
  bus_rsp_t  timer_rsp;
  bus_data_t time_count;
  bus_data_t load_value;
  bus_data_t cmp;
  logic      load;

  bus_decoder u_decoder (
    .clk       (clk),
    .rst       (rst),
    .bus_req   (bus_req),
    .bus_rsp   (bus_rsp),
    .bram_req  (bram_req),
    .uart_req  (uart_req),
    .timer_req (timer_req),
    .bram_rsp  (bram_rsp),
    .uart_rsp  (uart_rsp),
    .timer_rsp (timer_rsp)
  );

  bram_mem #(.BRAM_DEPTH(BRAM_DEPTH)) u_bram (
    .clk (clk),
    .rst (rst),
    .req (bram_req),
    .rsp (bram_rsp)
  );

  uart_periph #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart (
    .clk (clk),
    .rst (rst),
    .req (uart_req),
    .rsp (uart_rsp),
    .rx  (rx),
    .tx  (tx)
  );

  timer_regs u_timer_regs (
    .clk        (clk),
    .rst        (rst),
    .req        (timer_req),
    .rsp        (timer_rsp),
    .time_count (time_count),
    .load       (load),
    .load_value (load_value),
    .cmp        (cmp)
  );

  timer_count #(.RTC_DIV(RTC_DIV)) u_timer_count (
    .clk        (clk),
    .rst        (rst),
    .load       (load),
    .load_value (load_value),
    .cmp        (cmp),
    .time_count (time_count),
    .irq        (irq)
  );

endmodule

//--- tb_soc_periph.sv
`timescale 1ns/1ps

module tb_soc_periph;
  import soc_bus_pkg::*;
  import soc_map_pkg::*;

  localparam int bram_depth   = 256;
  localparam int clks_per_bit = 8;
  localparam int rtc_div      = 4;
  localparam int max_vectors  = 64;
  localparam int vec_cols     = 6;   // op, addr, wdata, wstrb, expected, mask
  localparam int bus_timeout  = 20;
  localparam int poll_limit   = 100;
  localparam int irq_timeout  = 400;
  localparam int fill_words   = 17;

  logic        clk;
  logic        rst;
  bus_req_t    bus_req;
  bus_rsp_t    bus_rsp;
  logic        rx;
  logic        tx;
  logic        irq;
  int unsigned cycles = 0;
  int          n_vec;
  bus_data_t   vectors [max_vectors*vec_cols];

  soc_periph #(
    .BRAM_DEPTH   (bram_depth),
    .CLKS_PER_BIT (clks_per_bit),
    .RTC_DIV      (rtc_div)
  ) u_dut (
    .clk     (clk),
    .rst     (rst),
    .bus_req (bus_req),
    .bus_rsp (bus_rsp),
    .rx      (rx),
    .tx      (tx),
    .irq     (irq)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    rx     <= tx;  // uart loopback
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("test failed");
    $fatal(1);
  endtask

  task automatic check_data(input string name, input bus_data_t exp, input bus_data_t act);
    if (act !== exp) begin
      abort_run($sformatf("[ERROR] %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_irq(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      abort_run($sformatf("[ERROR] %s: expected %b, actual %b", name, exp, act));
    end
  endtask

  function automatic bus_data_t xorshift(input bus_data_t s);
    bus_data_t x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic bus_addr_t ram_fill_addr(input int i);
    if (i == fill_words - 1) begin
      return 32'h0fff_fffc;  // just below the uart window
    end
    return bus_addr_t'(4 * i);
  endfunction

  task automatic bus_access(input bus_addr_t addr, input bus_data_t wdata,
                            input bus_strb_t wstrb, output bus_data_t rdata);
    int waited;
    waited = 0;
    @(posedge clk);
    bus_req <= '{valid: 1'b1, addr: addr, wdata: wdata, wstrb: wstrb};
    do begin
      @(posedge clk);
      waited++;
      if (waited > bus_timeout) begin
        abort_run($sformatf("no bus ready within %0d cycles for address %h",
                            bus_timeout, addr));
      end
    end while (bus_rsp.ready !== 1'b1);
    rdata = bus_rsp.rdata;
    bus_req.valid <= 1'b0;
  endtask

  task automatic fill_and_verify_ram();
    bus_data_t state;
    bus_data_t rd;
    bus_addr_t addr;
    state = 32'h4a7;
    for (int i = 0; i < fill_words; i++) begin
      state = xorshift(state);
      addr  = ram_fill_addr(i);
      bus_access(addr, state ^ addr, 4'hf, rd);
    end
    state = 32'h4a7;  // same sequence again
    for (int i = 0; i < fill_words; i++) begin
      state = xorshift(state);
      addr  = ram_fill_addr(i);
      bus_access(addr, '0, 4'h0, rd);
      check_data($sformatf("ram fill word at %h", addr), state ^ addr, rd);
    end
  endtask

  task automatic check_timer_advance();
    bus_data_t   rd;
    int unsigned start;
    int unsigned bound;
    start = cycles;
    bus_access(timer_base_addr | timer_time_offset, '0, 4'hf, rd);
    repeat (40) @(posedge clk);
    bus_access(timer_base_addr | timer_time_offset, '0, 4'h0, rd);
    bound = (cycles - start) / rtc_div;
    if (rd == '0 || rd > bound) begin
      abort_run($sformatf("[ERROR] timer count after load: expected 1 to %0d, actual %0d",
                          bound, rd));
    end
  endtask

  task automatic run_vector(input int n);
    bus_data_t op;
    bus_addr_t addr;
    bus_data_t wdata;
    bus_strb_t wstrb;
    bus_data_t exp;
    bus_data_t mask;
    bus_data_t rd;
    string     name;
    int        tries;
    op    = vectors[n*vec_cols];
    addr  = vectors[n*vec_cols+1];
    wdata = vectors[n*vec_cols+2];
    wstrb = bus_strb_t'(vectors[n*vec_cols+3]);
    exp   = vectors[n*vec_cols+4];
    mask  = vectors[n*vec_cols+5];
    name  = $sformatf("vector %0d (%c)", n, op[7:0]);
    tries = 0;
    case (op)
      32'h57: bus_access(addr, wdata, wstrb, rd);
      32'h52: begin
        bus_access(addr, '0, 4'h0, rd);
        check_data(name, exp & mask, rd & mask);
      end
      32'h50: begin
        do begin
          tries++;
          if (tries > poll_limit) begin
            abort_run($sformatf("polling %h in vector %0d never matched", addr, n));
          end
          bus_access(addr, '0, 4'h0, rd);
        end while ((rd & mask) !== (exp & mask));
      end
      32'h49: begin
        while (irq !== exp[0]) begin
          @(posedge clk);
          tries++;
          if (tries > irq_timeout) begin
            abort_run($sformatf("irq did not reach %b in vector %0d", exp[0], n));
          end
        end
      end
      default: abort_run($sformatf("vector %0d holds an unknown opcode %h", n, op));
    endcase
  endtask

  initial begin
    clk     = 1'b0;
    rst     = 1'b1;
    rx      = 1'b1;
    bus_req = '0;
    for (int i = 0; i < max_vectors*vec_cols; i++) begin
      vectors[i] = '0;
    end
    $readmemh("soc_periph_vectors.txt", vectors);
    n_vec = 0;
    while (n_vec < max_vectors && vectors[n_vec*vec_cols] !== '0) begin
      n_vec++;
    end
    if (n_vec == 0) begin
      abort_run("no vectors could be read from soc_periph_vectors.txt");
    end
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    check_irq("irq after reset", 1'b0, irq);
    fill_and_verify_ram();
    check_timer_advance();
    for (int n = 0; n < n_vec; n++) begin
      run_vector(n);
    end
    $display("test passed");
    $finish;
  end

endmodule

//--- soc_periph_vectors.txt
// columns: opcode addr wdata wstrb expected mask, all hex
// opcode is ascii, 57 write, 52 read, 50 poll read, 49 wait for irq level
49 00000000 00000000 0 00000000 00000001
// partial strobes on one ram word
57 00000100 11223344 f 00000000 00000000
57 00000100 aabbccdd 5 00000000 00000000
52 00000100 00000000 0 11bb33dd ffffffff
57 00000100 99000000 8 00000000 00000000
52 00000100 00000000 0 99bb33dd ffffffff
// uart loopback, first byte
57 10000000 000000a5 1 00000000 00000000
52 10000000 00000000 0 00000001 00000001
50 10000004 00000000 0 00000100 00000100
52 10000004 00000000 0 000000a5 000000ff
52 10000004 00000000 0 00000000 00000100
// second byte once the transmitter is idle
50 10000000 00000000 0 00000000 00000001
57 10000000 0000005a 1 00000000 00000000
50 10000004 00000000 0 00000100 00000100
52 10000004 00000000 0 0000005a 000000ff
52 10000004 00000000 0 00000000 00000100
// timer interrupt level
57 20000004 00000010 f 00000000 00000000
49 00000000 00000000 0 00000001 00000001
57 20000004 ffffffff f 00000000 00000000
49 00000000 00000000 0 00000000 00000001
52 20000004 00000000 0 ffffffff ffffffff

//--- soc_periph.f
soc_bus_pkg.sv
soc_map_pkg.sv
bus_decoder.sv
bram_mem.sv
uart_periph.sv
timer_regs.sv
timer_count.sv
soc_periph.sv
tb_soc_periph.sv

//--- Bender.yml
package:
  name: soc_periph

sources:
  # packages first, then leaf modules, then the top level
  - soc_bus_pkg.sv
  - soc_map_pkg.sv
  - bus_decoder.sv
  - bram_mem.sv
  - uart_periph.sv
  - timer_regs.sv
  - timer_count.sv
  - soc_periph.sv

  - target: test
    files:
      - tb_soc_periph.sv
